//--- bench/icache_trace.txt
# columns: fetch address (hex), expected kind (H hit, M miss, U uncached), expected word (hex)
# expected word is the byte address xor 0f0f0f0f
00001000 M 0f0f1f0f
00001004 H 0f0f1f0b
0000103c H 0f0f1f33
00001020 H 0f0f1f2f
a0000010 U af0f0f1f
a0000010 U af0f0f1f
00003008 M 0f0f3f07
0000300c H 0f0f3f03
00001000 M 0f0f1f0f
00001010 H 0f0f1f1f
00003008 M 0f0f3f07
12345670 M 1d3b597f
1234567c H 1d3b5973
a0ffff00 U aff0f00f
12345640 H 1d3b594f
00003000 H 0f0f3f0f
80000004 M 8f0f0f0b
80000038 H 8f0f0f37
b0000000 M bf0f0f0f
80000004 M 8f0f0f0b

//--- icache.f
verilog/icache_pkg.sv
verilog/icache_line_ram.sv
verilog/icache_tag_store.sv
verilog/refill_counter.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
bench/icache_props.sv
bench/icache_checker.sv
bench/icache_tb.sv

//--- run_sim.sh
#!/bin/bash
# build the icache testbench with Verilator and run it from the project root
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module icache_tb \
  -Mdir obj_dir -o icache_sim -f icache.f

./obj_dir/icache_sim +verilator+error+limit+100 | tee sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0

//--- bench/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

  localparam int CLK_PERIOD = 10;
  localparam int MAX_FETCHES = 64;
  localparam int CYCLES_PER_FETCH = 200;
  // memory content is the byte address xor this
  localparam word_t MEM_PATTERN = 32'h0F0F_0F0F;

  logic       clk;
  logic       rst;
  fetch_req_t fetch_req;
  fetch_rsp_t fetch_rsp;
  mem_ar_t    mem_ar;
  mem_r_t     mem_r;

  // trace contents, one entry per fetch
  logic [ADDR_W-1:0] trace_addr [MAX_FETCHES];
  logic [7:0]        trace_kind [MAX_FETCHES];
  word_t             trace_word [MAX_FETCHES];
  int                num_fetches;
  logic              trace_loaded;

  // expectation of the fetch in flight
  logic [7:0] exp_kind;
  word_t      exp_word;
  int         checked;
  int         errors;

  // memory model state
  int      seed;
  int      beat_n;
  mem_ar_t ar_prev;

  icache_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .fetch_req_i(fetch_req),
    .fetch_rsp_o(fetch_rsp),
    .mem_ar_o   (mem_ar),
    .mem_r_i    (mem_r)
  );

  icache_checker i_checker (
    .clk        (clk),
    .rst        (rst),
    .fetch_req_i(fetch_req),
    .fetch_rsp_i(fetch_rsp),
    .mem_ar_i   (mem_ar),
    .exp_kind_i (exp_kind),
    .exp_word_i (exp_word),
    .checked_o  (checked),
    .errors_o   (errors)
  );

  bind icache_ctrl icache_props i_props (
    .clk   (clk),
    .rst   (rst),
    .ar_i  (mem_ar_o),
    .r_i   (mem_r_i),
    .rsp_i (fetch_rsp_o),
    .last_i(refill_last_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic word_t mem_word(input logic [ADDR_W-1:0] addr);
    return addr ^ MEM_PATTERN;
  endfunction

  task automatic load_trace(output bit ok);
    int                fd;
    int                n;
    string             line;
    logic [ADDR_W-1:0] a;
    logic [7:0]        k;
    word_t             w;
    num_fetches = 0;
    fd = $fopen("bench/icache_trace.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && num_fetches < MAX_FETCHES) begin
        line = "";
        void'($fgets(line, fd));
        // skip blank and comment lines
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %c %h", a, k, w);
          if (n == 3) begin
            trace_addr[num_fetches] = a;
            trace_kind[num_fetches] = k;
            trace_word[num_fetches] = w;
            num_fetches++;
          end
        end
      end
      $fclose(fd);
    end
    ok = (num_fetches > 0);
  endtask

  // held until the response pulse, next fetch on the following cycle
  task automatic run_fetch(input int i);
    #1;
    fetch_req.valid = 1'b1;
    fetch_req.addr = trace_addr[i];
    exp_kind = trace_kind[i];
    exp_word = trace_word[i];
    do begin
      @(negedge clk);
    end while (fetch_rsp.valid !== 1'b1);
    @(posedge clk);
  endtask

  // memory, beats go out 1 ns after the edge with random gaps
  initial begin
    mem_r = '0;
    seed = 77964;
    beat_n = 0;
    ar_prev = '0;
    forever begin
      @(posedge clk);
      #1;
      // a beat moved on this edge if both sides were valid
      if (ar_prev.valid === 1'b1 && mem_r.valid === 1'b1) begin
        beat_n = (beat_n == int'(ar_prev.len)) ? 0 : beat_n + 1;
      end
      ar_prev = mem_ar;
      mem_r.valid = (mem_ar.valid === 1'b1) && (($random(seed) & 3) != 0);
      mem_r.data = mem_word(mem_ar.addr + 32'(4 * beat_n));
    end
  end

  // watchdog scaled by the trace length
  initial begin
    wait (trace_loaded === 1'b1);
    repeat (num_fetches * CYCLES_PER_FETCH) @(posedge clk);
    $display("timeout: fetches still pending after %0d cycles", num_fetches * CYCLES_PER_FETCH);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    bit loaded;
    fetch_req = '0;
    exp_kind = '0;
    exp_word = '0;
    rst = 1'b1;
    trace_loaded = 1'b0;
    load_trace(loaded);
    if (!loaded) begin
      $display("error: no fetches could be read from bench/icache_trace.txt");
      $display("Testbench failed");
      $finish;
    end else begin
      trace_loaded = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      // idle cycles, nothing may move before the first fetch
      repeat (3) @(posedge clk);
      for (int i = 0; i < num_fetches; i++) begin
        run_fetch(i);
      end
      #1;
      fetch_req = '0;
      repeat (4) @(posedge clk);
      $display("summary: %0d of %0d fetches checked, %0d errors, %0d assertion failures",
               checked, num_fetches, errors, i_dut.i_ctrl.i_props.violations);
      if (checked == num_fetches && errors == 0 && i_dut.i_ctrl.i_props.violations == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- bench/icache_checker.sv
`timescale 1ns/10ps
`default_nettype none

module icache_checker import icache_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire fetch_req_t fetch_req_i,
  input  wire fetch_rsp_t fetch_rsp_i,
  input  wire mem_ar_t    mem_ar_i,
  input  wire logic [7:0] exp_kind_i,
  input  wire word_t      exp_word_i,
  output int              checked_o,
  output int              errors_o
);

  logic              busy;
  // request valid at the previous sample
  logic              ar_seen;
  logic [ADDR_W-1:0] cur_addr;
  int                cycles;
  int                requests;
  int                errors_at_start;

  initial begin
    checked_o = 0;
    errors_o = 0;
    busy = 1'b0;
    ar_seen = 1'b0;
  end

  task automatic check_request();
    logic [ADDR_W-1:0] line_base;
    line_base = {cur_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    requests++;
    if (exp_kind_i == "H" || requests > 1) begin
      $display("error: extra memory request to %h while fetching %h", mem_ar_i.addr, cur_addr);
      errors_o++;
    end else if (exp_kind_i == "M" && (mem_ar_i.addr != line_base || mem_ar_i.len != BURST_LEN)) begin
      $display("FAILED at %0t: refill request %h len %0d, expected %h len %0d",
               $time, mem_ar_i.addr, mem_ar_i.len, line_base, BURST_LEN);
      errors_o++;
    end else if (exp_kind_i == "U" && (mem_ar_i.addr != cur_addr || mem_ar_i.len != 8'd0)) begin
      $display("FAILED at %0t: uncached request %h len %0d, expected %h len 0",
               $time, mem_ar_i.addr, mem_ar_i.len, cur_addr);
      errors_o++;
    end
  endtask

  task automatic check_response();
    if (fetch_rsp_i.word !== exp_word_i) begin
      $display("FAILED at %0t: fetch %h returned %h, expected %h",
               $time, cur_addr, fetch_rsp_i.word, exp_word_i);
      errors_o++;
    end
    // hits answer in the cycle after the request is taken
    if (exp_kind_i == "H" && cycles != 1) begin
      $display("FAILED at %0t: hit on %h took %0d cycles, expected 1", $time, cur_addr, cycles);
      errors_o++;
    end
    if ((exp_kind_i == "M" || exp_kind_i == "U") && requests == 0) begin
      $display("error: fetch %h was answered without a memory request", cur_addr);
      errors_o++;
    end
    checked_o++;
    $display("fetch %0d %c %h -> %h %s", checked_o, exp_kind_i, cur_addr, fetch_rsp_i.word,
             (errors_o == errors_at_start) ? "ok" : "ERROR");
  endtask

  // ports settle by mid-cycle, sample on the falling edge
  always @(negedge clk) begin
    if (rst) begin
      busy = 1'b0;
    end else if (busy) begin
      cycles++;
      if (mem_ar_i.valid && !ar_seen) begin
        check_request();
      end
      if (fetch_rsp_i.valid) begin
        check_response();
        busy = 1'b0;
      end
    end else begin
      if (mem_ar_i.valid && !ar_seen) begin
        $display("error: memory request to %h with no fetch in progress", mem_ar_i.addr);
        errors_o++;
      end
      if (fetch_rsp_i.valid) begin
        $display("error: response at %0t with no fetch in progress", $time);
        errors_o++;
      end
      // new fetch on the port
      if (fetch_req_i.valid) begin
        busy = 1'b1;
        cur_addr = fetch_req_i.addr;
        cycles = 0;
        requests = 0;
        errors_at_start = errors_o;
      end
    end
    ar_seen = mem_ar_i.valid;
  end

endmodule

`default_nettype wire

//--- bench/icache_props.sv
`timescale 1ns/10ps
`default_nettype none

module icache_props import icache_pkg::*; (
  input wire logic       clk,
  input wire logic       rst,
  input wire mem_ar_t    ar_i,
  input wire mem_r_t     r_i,
  input wire fetch_rsp_t rsp_i,
  input wire logic       last_i
);

  // failed assertions so far
  int violations = 0;

  logic final_beat;

  // beat that ends the burst, single beat or last of a refill
  assign final_beat = r_i.valid && (ar_i.len == 8'd0 || last_i);

  ar_stable: assert property (@(posedge clk) disable iff (rst)
    ar_i.valid && !final_beat |=> $stable(ar_i))
    else begin
      violations = violations + 1;
      $error("memory request changed before its last beat");
    end

  rsp_not_during_ar: assert property (@(posedge clk) disable iff (rst)
    !(rsp_i.valid && ar_i.valid))
    else begin
      violations = violations + 1;
      $error("fetch response while a memory request is open");
    end

  // only single beat or full line
  len_legal: assert property (@(posedge clk) disable iff (rst)
    ar_i.valid |-> (ar_i.len == 8'd0 || ar_i.len == BURST_LEN))
    else begin
      violations = violations + 1;
      $error("memory request with illegal length code");
    end

endmodule

`default_nettype wire

//--- verilog/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire fetch_req_t fetch_req_i,
  output fetch_rsp_t      fetch_rsp_o,
  output mem_ar_t         mem_ar_o,
  input  wire mem_r_t     mem_r_i
);

  // controller to tag store
  logic [INDEX_W-1:0]    tag_index;
  tag_t                  tag;
  logic                  tag_write;
  logic                  hit;

  // controller to refill counter
  logic                  refill_start;
  logic                  refill_beat;
  logic [WORD_SEL_W-1:0] refill_word;
  logic                  refill_last;

  // controller to data array
  logic [DATA_AW-1:0]    data_addr;
  logic                  data_we;
  word_t                 data_wdata;
  word_t                 data_rdata;

  icache_ctrl i_ctrl (
    .clk           (clk),
    .rst           (rst),
    .fetch_req_i   (fetch_req_i),
    .fetch_rsp_o   (fetch_rsp_o),
    .mem_ar_o      (mem_ar_o),
    .mem_r_i       (mem_r_i),
    .tag_index_o   (tag_index),
    .tag_o         (tag),
    .tag_write_o   (tag_write),
    .hit_i         (hit),
    .refill_start_o(refill_start),
    .refill_beat_o (refill_beat),
    .refill_word_i (refill_word),
    .refill_last_i (refill_last),
    .data_addr_o   (data_addr),
    .data_we_o     (data_we),
    .data_wdata_o  (data_wdata),
    .data_rdata_i  (data_rdata)
  );

  icache_tag_store i_tag_store (
    .clk    (clk),
    .rst    (rst),
    .index_i(tag_index),
    .tag_i  (tag),
    .write_i(tag_write),
    .hit_o  (hit)
  );

  refill_counter i_refill_counter (
    .clk    (clk),
    .rst    (rst),
    .start_i(refill_start),
    .beat_i (refill_beat),
    .word_o (refill_word),
    .last_o (refill_last)
  );

  // 2048 words, one line per 16 entries
  icache_line_ram #(
    .entry_t(word_t),
    .DEPTH  (DATA_DEPTH),
    .AW     (DATA_AW)
  ) i_data_ram (
    .clk    (clk),
    .addr_i (data_addr),
    .we_i   (data_we),
    .wdata_i(data_wdata),
    .rdata_o(data_rdata)
  );

endmodule

`default_nettype wire

//--- verilog/icache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst,
  // fetch port
  input  wire fetch_req_t            fetch_req_i,
  output fetch_rsp_t                 fetch_rsp_o,
  // memory port
  output mem_ar_t                    mem_ar_o,
  input  wire mem_r_t                mem_r_i,
  // tag store
  output logic [INDEX_W-1:0]         tag_index_o,
  output tag_t                       tag_o,
  output logic                       tag_write_o,
  input  wire logic                  hit_i,
  // refill counter
  output logic                       refill_start_o,
  output logic                       refill_beat_o,
  input  wire logic [WORD_SEL_W-1:0] refill_word_i,
  input  wire logic                  refill_last_i,
  // data array
  output logic [DATA_AW-1:0]         data_addr_o,
  output logic                       data_we_o,
  output word_t                      data_wdata_o,
  input  wire word_t                 data_rdata_i
);

  icache_state_t state_q;

  // registered fetch address
  addr_fields_t addr_q;
  addr_fields_t req_fields;
  addr_fields_t line_addr;

  // memory request register
  logic              ar_valid_q;
  logic [ADDR_W-1:0] ar_addr_q;
  logic [7:0]        ar_len_q;

  // uncached word, returned straight from the beat
  logic  unc_valid_q;
  word_t unc_word_q;

  logic beat;
  logic uncached;
  logic lookup_hit;
  logic lookup_miss;

  assign req_fields = fetch_req_i.addr;

  // line-aligned refill address
  assign line_addr = '{tag: addr_q.tag, index: addr_q.index, word: '0, byte_off: '0};

  // bypass decode, only from the registered address
  assign uncached = (addr_q[ADDR_W-1 -: 4] == UNCACHED_REGION);

  // memory always accepts, so a beat is valid on both sides
  assign beat = ar_valid_q && mem_r_i.valid;

  assign lookup_hit = (state_q == LOOKUP) && !uncached && hit_i;
  assign lookup_miss = (state_q == LOOKUP) && !uncached && !hit_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      ar_valid_q <= 1'b0;
      unc_valid_q <= 1'b0;
    end else begin
      // response pulse lasts one cycle
      unc_valid_q <= 1'b0;
      case (state_q)
        IDLE: begin
          // skip the request still held during the uncached pulse
          if (fetch_req_i.valid && !unc_valid_q) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (uncached) begin
            state_q <= UNCACHED;
            ar_valid_q <= 1'b1;
          end else if (hit_i) begin
            state_q <= IDLE;
          end else begin
            state_q <= REFILL;
            ar_valid_q <= 1'b1;
          end
        end
        REFILL: begin
          if (beat && refill_last_i) begin
            state_q <= REREAD;
            ar_valid_q <= 1'b0;
          end
        end
        REREAD: begin
          // arrays are read again with the new line
          state_q <= LOOKUP;
        end
        UNCACHED: begin
          if (beat) begin
            state_q <= IDLE;
            ar_valid_q <= 1'b0;
            unc_valid_q <= 1'b1;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (state_q == IDLE && fetch_req_i.valid) begin
      addr_q <= req_fields;
    end
    if (state_q == LOOKUP) begin
      ar_addr_q <= uncached ? addr_q : line_addr;
      ar_len_q <= uncached ? 8'd0 : BURST_LEN;
    end
    if (state_q == UNCACHED && beat) begin
      unc_word_q <= mem_r_i.data;
    end
  end

  assign mem_ar_o = '{valid: ar_valid_q, addr: ar_addr_q, len: ar_len_q};

  // idle presents the live request so the lookup has data a cycle later
  assign tag_index_o = (state_q == IDLE) ? req_fields.index : addr_q.index;
  assign tag_o = addr_q.tag;

  assign refill_start_o = lookup_miss;
  assign refill_beat_o = (state_q == REFILL) && beat;
  // tag and valid bit go in with the final beat
  assign tag_write_o = refill_beat_o && refill_last_i;

  always_comb begin
    if (state_q == IDLE) begin
      data_addr_o = {req_fields.index, req_fields.word};
    end else if (state_q == REFILL) begin
      data_addr_o = {addr_q.index, refill_word_i};
    end else begin
      data_addr_o = {addr_q.index, addr_q.word};
    end
  end

  assign data_we_o = refill_beat_o;
  assign data_wdata_o = mem_r_i.data;

  // hit answers from the array, bypass from its own register
  assign fetch_rsp_o = '{
    valid: lookup_hit || unc_valid_q,
    word:  unc_valid_q ? unc_word_q : data_rdata_i
  };

endmodule

`default_nettype wire

//--- verilog/refill_counter.sv
`timescale 1ns/10ps
`default_nettype none

module refill_counter import icache_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  start_i,
  input  wire logic                  beat_i,
  output logic [WORD_SEL_W-1:0]      word_o,
  output logic                       last_o
);

  // accepted beats of the current refill
  logic [WORD_SEL_W-1:0] count_q;

  always_ff @(posedge clk) begin
    if (rst || start_i) begin
      count_q <= '0;
    end else if (beat_i) begin
      // wraps to zero after the last beat
      count_q <= count_q + 1'b1;
    end
  end

  // beat n lands in word n of the line
  assign word_o = count_q;

  // final beat of the burst
  assign last_o = (count_q == BURST_LEN[WORD_SEL_W-1:0]);

endmodule

`default_nettype wire

//--- verilog/icache_tag_store.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tag_store import icache_pkg::*; (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic [INDEX_W-1:0] index_i,
  input  wire tag_t               tag_i,
  input  wire logic               write_i,
  output logic                    hit_o
);

  // one valid bit per line
  logic [NUM_LINES-1:0] valid_q;
  // index of the lookup in flight
  logic [INDEX_W-1:0]   index_q;
  tag_t                 stored_tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (write_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  // matches the one-cycle read of the tag ram
  always_ff @(posedge clk) begin
    index_q <= index_i;
  end

  icache_line_ram #(
    .entry_t(tag_t),
    .DEPTH  (NUM_LINES),
    .AW     (INDEX_W)
  ) i_tag_ram (
    .clk    (clk),
    .addr_i (index_i),
    .we_i   (write_i),
    .wdata_i(tag_i),
    .rdata_o(stored_tag)
  );

  // tag_i is the registered tag of the lookup
  assign hit_o = valid_q[index_q] && (stored_tag == tag_i);

endmodule

`default_nettype wire

//--- verilog/icache_line_ram.sv
`timescale 1ns/10ps
`default_nettype none

module icache_line_ram #(
  parameter type entry_t = logic [31:0],
  parameter int DEPTH = 128,
  parameter int AW = 7
) (
  input  wire logic          clk,
  input  wire logic [AW-1:0] addr_i,
  input  wire logic          we_i,
  input  wire entry_t        wdata_i,
  output entry_t             rdata_o
);

  // storage, no reset on the array
  entry_t mem_q [DEPTH];

  // single port, read returns the old entry on a write cycle
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i];
  end

endmodule

`default_nettype wire

//--- verilog/icache_pkg.sv
`default_nettype none

package icache_pkg;

  // address geometry
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int NUM_LINES = 128;
  localparam int INDEX_W = 7;
  localparam int OFFSET_W = 6;
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  // refill burst, one 32-bit word per beat
  localparam int WORDS_PER_LINE = 16;
  localparam int WORD_SEL_W = 4;
  localparam logic [7:0] BURST_LEN = 8'd15;

  // data array is addressed by {index, word select}
  localparam int DATA_AW = INDEX_W + WORD_SEL_W;
  localparam int DATA_DEPTH = NUM_LINES * WORDS_PER_LINE;

  // top nibble of the bypass space
  localparam logic [3:0] UNCACHED_REGION = 4'hA;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [WORD_W-1:0] word_t;

  typedef struct packed {
    tag_t                  tag;
    logic [INDEX_W-1:0]    index;
    logic [WORD_SEL_W-1:0] word;
    logic [1:0]            byte_off;
  } addr_fields_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic  valid;
    word_t word;
  } fetch_rsp_t;

  // held from request until the last beat
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } mem_ar_t;

  typedef struct packed {
    logic  valid;
    word_t data;
  } mem_r_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    REREAD,
    UNCACHED
  } icache_state_t;

endpackage

`default_nettype wire
